// File: rtl/tile_pkg.sv
// Tile bus package with the Wishbone request and response structs, address map and sizes
package tile_pkg;

   // Bus widths
   localparam int unsigned ADDR_W = 32;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned SEL_W  = 4;    // One select per byte lane

   // Address map, matched on the top address bits

   // Local data memory covers 0x00000000 to 0x7fffffff
   localparam int unsigned                DM_MATCH_BITS = 1;
   localparam logic [DM_MATCH_BITS-1:0]   DM_MATCH      = 1'b0;

   // Network adapter window, 0xe0000000 to 0xefffffff
   localparam int unsigned                EXT_MATCH_BITS = 4;
   localparam logic [EXT_MATCH_BITS-1:0]  EXT_MATCH      = 4'he;

   // Everything else is unmapped and answered with err

   // Default sizes, overridden from the top level
   localparam int unsigned DM_WORDS_DEFAULT    = 256;   // Memory depth in words
   localparam int unsigned NUM_MASTERS_DEFAULT = 2;     // Two bus masters per tile

   // Master to slave side of a Wishbone classic cycle
   typedef struct packed {
      logic              cyc;    // Bus cycle in progress
      logic              stb;    // Transfer strobe
      logic              we;     // Write enable
      logic [SEL_W-1:0]  sel;    // Byte selects
      logic [ADDR_W-1:0] adr;    // Byte address
      logic [DATA_W-1:0] dat;    // Write data
   } wb_req_t;

   // Slave to master side
   typedef struct packed {
      logic              ack;    // Normal termination
      logic              err;    // Error termination
      logic [DATA_W-1:0] dat;    // Read data, valid with ack
   } wb_rsp_t;

   // Request is 71 bits and response 34 bits wide

endpackage

// File: rtl/bus_arbiter.sv
// Bus arbiter granting the shared Wishbone bus to one master in round-robin order
module bus_arbiter #(
   parameter int unsigned NUM_MASTERS = tile_pkg::NUM_MASTERS_DEFAULT
) (
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  tile_pkg::wb_req_t [NUM_MASTERS-1:0] m_req_i,     // Requests of all masters
   output tile_pkg::wb_rsp_t [NUM_MASTERS-1:0] m_rsp_o,     // Responses back to masters
   output tile_pkg::wb_req_t                   bus_req_o,   // Granted request
   input  tile_pkg::wb_rsp_t                   bus_rsp_i    // Response of the decoder
);

   // At least one index bit, also for a single master
   localparam int unsigned IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

   logic             busy_q;        // Bus owned by grant_q
   logic [IDX_W-1:0] grant_q;       // Current owner
   logic [IDX_W-1:0] last_q;        // Previous owner, round-robin pointer
   logic             pick_vld;      // Some master raises cyc
   logic [IDX_W-1:0] pick_idx;      // Winner for an idle bus
   logic             release_bus;   // Owner drops cyc

   // Search starts one past the previous owner and wraps around
   always_comb begin
      int unsigned cand;
      cand     = 0;
      pick_vld = 1'b0;
      pick_idx = '0;
      for (int unsigned k = 1; k <= NUM_MASTERS; k++) begin
         cand = (last_q + k) % NUM_MASTERS;
         if (!pick_vld && m_req_i[cand].cyc) begin
            pick_vld = 1'b1;               // First hit wins
            pick_idx = IDX_W'(cand);
         end
      end
   end

   // Cycle ends when the owner lets go of cyc, stb alone keeps nothing
   assign release_bus = busy_q && !m_req_i[grant_q].cyc;

   // Grant FSM, two states folded into busy_q
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         busy_q  <= 1'b0;
         grant_q <= '0;
         last_q  <= IDX_W'(NUM_MASTERS - 1);   // Master 0 has priority after reset
      end else if (!busy_q) begin
         if (pick_vld) begin
            busy_q  <= 1'b1;                   // Grant at the next edge
            grant_q <= pick_idx;
         end
      end else if (release_bus) begin
         busy_q <= 1'b0;                       // One idle cycle before the next grant
         last_q <= grant_q;                    // Owner loses priority next round
      end
   end

   // Request path, nothing leaks through while idle
   always_comb begin
      bus_req_o = '0;
      if (busy_q) begin
         bus_req_o = m_req_i[grant_q];
      end
   end

   // Response path, only the owner sees ack and err
   always_comb begin
      for (int unsigned i = 0; i < NUM_MASTERS; i++) begin
         m_rsp_o[i] = '0;                      // Waiting masters see a quiet bus
         if (busy_q && (grant_q == IDX_W'(i))) begin
            m_rsp_o[i] = bus_rsp_i;
         end
      end
   end

   // A master that is not granted keeps its request stable until it owns the bus
   // Its cyc alone counts as a request, stb is only looked at by the slaves
   // No preemption, a long ext access holds the bus until its ack or err

endmodule

// File: rtl/addr_decoder.sv
// Address decoder selecting the DM or external slave and muxing their responses
module addr_decoder (
   input  tile_pkg::wb_req_t bus_req_i,   // From the arbiter
   output tile_pkg::wb_rsp_t bus_rsp_o,   // To the arbiter
   output tile_pkg::wb_req_t dm_req_o,    // Local data memory
   input  tile_pkg::wb_rsp_t dm_rsp_i,
   output tile_pkg::wb_req_t ext_req_o,   // Network adapter window
   input  tile_pkg::wb_rsp_t ext_rsp_i
);

   import tile_pkg::*;

   // Target of the current address
   typedef enum logic [1:0] {
      SLV_DM,
      SLV_EXT,
      SLV_NONE
   } slave_sel_e;

   logic       dm_hit;    // Top bit matches DM window
   logic       ext_hit;   // Top nibble matches ext window
   logic       access;    // Active transfer on the bus
   slave_sel_e slv_sel;

   // Window compares on the top address bits only
   assign dm_hit  = (bus_req_i.adr[ADDR_W-1 -: DM_MATCH_BITS] == DM_MATCH);
   assign ext_hit = (bus_req_i.adr[ADDR_W-1 -: EXT_MATCH_BITS] == EXT_MATCH);
   assign access  = bus_req_i.cyc & bus_req_i.stb;

   // Windows are disjoint, order only matters for readability
   always_comb begin
      if (dm_hit) begin
         slv_sel = SLV_DM;
      end else if (ext_hit) begin
         slv_sel = SLV_EXT;
      end else begin
         slv_sel = SLV_NONE;
      end
   end

   // Payload goes to both slaves, strobes only to the selected one
   always_comb begin
      dm_req_o     = bus_req_i;
      dm_req_o.cyc = bus_req_i.cyc & (slv_sel == SLV_DM);
      dm_req_o.stb = bus_req_i.stb & (slv_sel == SLV_DM);
   end

   always_comb begin
      ext_req_o     = bus_req_i;                            // Address and data unchanged
      ext_req_o.cyc = bus_req_i.cyc & (slv_sel == SLV_EXT);
      ext_req_o.stb = bus_req_i.stb & (slv_sel == SLV_EXT);
   end

   // Response mux, zero cycles
   always_comb begin
      bus_rsp_o = '0;
      case (slv_sel)
         SLV_DM: begin
            bus_rsp_o = dm_rsp_i;
         end
         SLV_EXT: begin
            bus_rsp_o = ext_rsp_i;                          // Forwarded as is
         end
         default: begin
            bus_rsp_o.err = access;                         // Same cycle as stb
         end
      endcase
   end

   // Err on an unmapped address lasts as long as stb, no ack ever
   // Read data stays zero for an unmapped access
   // A slave never sees stb outside its own window, so it cannot ack late for another

endmodule

// File: rtl/dm_sram.sv
// Local data memory, single-port word array with byte selects and a one-cycle ack
module dm_sram #(
   parameter int unsigned DM_WORDS = tile_pkg::DM_WORDS_DEFAULT
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   import tile_pkg::*;

   localparam int unsigned WORD_AW  = (DM_WORDS > 1) ? $clog2(DM_WORDS) : 1;
   localparam int unsigned BYTE_W   = DATA_W / SEL_W;   // Lane width
   localparam int unsigned ADDR_LSB = $clog2(SEL_W);    // Byte offset bits

   logic [DATA_W-1:0]  mem [DM_WORDS];   // Storage
   logic [WORD_AW-1:0] word_idx;
   logic               access;           // New transfer this cycle
   logic               ack_q;
   logic [DATA_W-1:0]  rdata_q;

   // Word address wraps at the memory depth
   assign word_idx = WORD_AW'(req_i.adr[ADDR_W-1:ADDR_LSB] % DM_WORDS);

   // Strobe still high during ack must not start a second access
   assign access = req_i.cyc & req_i.stb & ~ack_q;

   // Ack one cycle after stb, single pulse
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Array and read register
   always_ff @(posedge clk) begin
      if (access) begin
         rdata_q <= mem[word_idx];               // Old data on a write, unused then
         if (req_i.we) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (req_i.sel[b]) begin
                  mem[word_idx][BYTE_W*b +: BYTE_W] <= req_i.dat[BYTE_W*b +: BYTE_W];
               end
            end
         end
      end
   end

   // Read data valid while ack is high
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;                      // Every word in the window exists
   assign rsp_o.dat = rdata_q;

   // Partial writes leave unselected lanes as they were
   // Reads ignore sel and return the full word

endmodule

// File: rtl/tile_bus_top.sv
// Tile bus subsystem with two Wishbone masters, the local data memory and the ext window
module tile_bus_top #(
   parameter int unsigned NUM_MASTERS = tile_pkg::NUM_MASTERS_DEFAULT,
   parameter int unsigned DM_WORDS    = tile_pkg::DM_WORDS_DEFAULT
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t m0_req_i,    // Master 0
   output tile_pkg::wb_rsp_t m0_rsp_o,
   input  tile_pkg::wb_req_t m1_req_i,    // Master 1
   output tile_pkg::wb_rsp_t m1_rsp_o,
   output tile_pkg::wb_req_t ext_req_o,   // Network adapter slave window
   input  tile_pkg::wb_rsp_t ext_rsp_i
);

   import tile_pkg::*;

   wb_req_t [NUM_MASTERS-1:0] m_req;   // Master bundle into the arbiter
   wb_rsp_t [NUM_MASTERS-1:0] m_rsp;
   wb_req_t                   bus_req; // Shared bus
   wb_rsp_t                   bus_rsp;
   wb_req_t                   dm_req;  // Memory slave
   wb_rsp_t                   dm_rsp;

   // Master ports into the arbiter array
   assign m_req[0] = m0_req_i;
   assign m_req[1] = m1_req_i;
   assign m0_rsp_o = m_rsp[0];
   assign m1_rsp_o = m_rsp[1];

   // Slots beyond the two ports stay silent
   for (genvar i = 2; i < NUM_MASTERS; i++) begin : gen_idle_master
      assign m_req[i] = '0;
   end

   bus_arbiter #(
      .NUM_MASTERS (NUM_MASTERS)
   ) u_arbiter (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .m_req_i   (m_req),
      .m_rsp_o   (m_rsp),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   addr_decoder u_decoder (
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp),
      .dm_req_o  (dm_req),
      .dm_rsp_i  (dm_rsp),
      .ext_req_o (ext_req_o),   // Straight out of the tile
      .ext_rsp_i (ext_rsp_i)
   );

   dm_sram #(
      .DM_WORDS (DM_WORDS)
   ) u_dm (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (dm_req),
      .rsp_o   (dm_rsp)
   );

endmodule

// File: tb/tb_wb_master.sv
// Wishbone master model with a shadow of its own DM quarter and response checks
module tb_wb_master #(
   parameter int unsigned MASTER_ID = 0,
   parameter bit          DIRECTED  = 1'b0,   // Runs the directed tests in phase 2
   parameter int unsigned N_RANDOM  = 100
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic [1:0]        phase_i,   // Phase to run from tb_top
   input  tile_pkg::wb_rsp_t rsp_i,
   output tile_pkg::wb_req_t req_o,
   output logic [1:0]        done_o,    // Last phase finished
   output logic              fail_o
);

   import tile_pkg::*;

   localparam int unsigned REGION_WORDS = 64;                        // Quarter of the DM
   localparam logic [31:0] REGION_BASE  = 32'(MASTER_ID * REGION_WORDS * 4);
   localparam time         DRIVE_DLY    = 1;

   logic [31:0] shadow [REGION_WORDS];   // Expected DM contents
   int          seed;

   // Park this master with fail_o raised
   task automatic raise_failure();
      fail_o = 1'b1;
      forever @(posedge clk);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp) else begin
         $display("error at %0t: master %0d %s expected %h got %h",
                  $time, MASTER_ID, name, exp, got);
         raise_failure();
      end
   endtask

   // One classic cycle, held until ack or err; lat counts edges to the end
   task automatic transfer(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                           input logic [31:0] wdat, output wb_rsp_t rsp,
                           output int unsigned lat);
      @(posedge clk);
      #DRIVE_DLY;
      req_o = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
      lat = 0;
      @(negedge clk);                            // Responses settled mid cycle
      while (!(rsp_i.ack || rsp_i.err)) begin
         lat++;
         @(negedge clk);
      end
      rsp = rsp_i;
      assert (!(rsp.ack && rsp.err)) else begin
         $display("master %0d got ack and err together at %0t", MASTER_ID, $time);
         raise_failure();
      end
      @(posedge clk);
      #DRIVE_DLY;
      req_o = '0;                                // Drop stb the cycle after
   endtask

   function automatic logic [31:0] fill_pattern(input logic [31:0] adr);
      return (adr * 32'h9e3779b1) ^ 32'h0f1e2d3c;
   endfunction

   task automatic dm_write(input int unsigned word, input logic [3:0] sel,
                           input logic [31:0] data);
      wb_rsp_t     rsp;
      int unsigned lat;
      transfer(1'b1, sel, REGION_BASE + 32'(word * 4), data, rsp, lat);
      check_value("ack", 32'd1, 32'(rsp.ack));
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            shadow[word][8*b +: 8] = data[8*b +: 8];   // Selected lanes only
         end
      end
   endtask

   task automatic dm_read(input int unsigned word, input bit check_lat);
      wb_rsp_t     rsp;
      int unsigned lat;
      transfer(1'b0, 4'hf, REGION_BASE + 32'(word * 4), 32'h0, rsp, lat);
      check_value("ack", 32'd1, 32'(rsp.ack));
      check_value("dat", shadow[word], rsp.dat);
      if (check_lat) begin
         check_value("ack latency", 32'd2, lat);    // Grant plus DM ack on an idle bus
      end
   endtask

   task automatic ext_access(input logic we, input logic [31:0] adr, input logic [31:0] data);
      wb_rsp_t     rsp;
      int unsigned lat;
      transfer(we, 4'hf, adr, data, rsp, lat);
      check_value("ack", 32'd1, 32'(rsp.ack));
      if (!we) begin
         check_value("ext dat", adr ^ 32'h5a5a5a5a, rsp.dat);
      end
   endtask

   task automatic unmapped_access(input logic we, input logic [31:0] adr);
      wb_rsp_t     rsp;
      int unsigned lat;
      transfer(we, 4'hf, adr, 32'h1234_5678, rsp, lat);
      check_value("err", 32'd1, 32'(rsp.err));
   endtask

   task automatic run_directed();
      dm_write(5, 4'hf, 32'hdeadbeef);           // Full word
      dm_read(5, 1'b1);
      dm_write(6, 4'b0101, 32'h11223344);        // Lanes 0 and 2
      dm_read(6, 1'b1);
      dm_write(7, 4'b1000, 32'haabbccdd);
      dm_read(7, 1'b1);
      ext_access(1'b1, 32'he000_0010, 32'h0badf00d);
      ext_access(1'b0, 32'he000_1234, 32'h0);
      ext_access(1'b0, 32'heffffffc, 32'h0);     // Top of the window
      unmapped_access(1'b0, 32'h9000_0000);
      unmapped_access(1'b1, 32'hf000_0000);
   endtask

   task automatic run_random();
      logic [31:0] rnd;
      logic [31:0] wdat;
      for (int n = 0; n < N_RANDOM; n++) begin
         rnd  = $random(seed);
         wdat = $random(seed);
         case (rnd[2:0])
            3'd0, 3'd1, 3'd2: dm_write(rnd[13:8], (rnd[7:4] == 4'h0) ? 4'hf : rnd[7:4], wdat);
            3'd3, 3'd4:       dm_read(rnd[13:8], 1'b0);
            3'd5, 3'd6:       ext_access(rnd[3], {4'he, rnd[31:6], 2'b00}, wdat);
            default:          unmapped_access(rnd[3], {2'b10, rnd[5:4], rnd[31:6], 2'b00});
         endcase
      end
      for (int w = 0; w < REGION_WORDS; w++) begin
         dm_read(w, 1'b0);                       // Sweep for writes of the other master
      end
   endtask

   // No response may arrive outside a bus cycle
   always @(negedge clk) begin
      if (rst_n_i && !req_o.cyc) begin
         assert (!rsp_i.ack && !rsp_i.err) else begin
            $display("master %0d saw ack or err without a bus cycle at %0t", MASTER_ID, $time);
            raise_failure();
         end
      end
   end

   initial begin
      req_o  = '0;
      done_o = 2'd0;
      fail_o = 1'b0;
      seed   = 32'hd674821b;
      wait (phase_i == 2'd1);
      for (int w = 0; w < REGION_WORDS; w++) begin
         dm_write(w, 4'hf, fill_pattern(REGION_BASE + 32'(w * 4)));
      end
      done_o = 2'd1;
      wait (phase_i == 2'd2);
      if (DIRECTED) begin
         run_directed();
      end
      done_o = 2'd2;
      wait (phase_i == 2'd3);
      run_random();
      done_o = 2'd3;
   end

endmodule

// File: tb/tb_top.sv
// Testbench top for the tile bus with two master models, an ext slave model and a cycle limit
module tb_top;

   import tile_pkg::*;

   localparam int unsigned N_RANDOM       = 100;
   localparam int unsigned TIMEOUT_CYCLES = 4000;   // About 470 transfers, under 8 cycles each
   localparam time         DRIVE_DLY      = 1;

   logic        clk;
   logic        rst_n;
   logic [1:0]  phase;
   logic [1:0]  m0_done;
   logic [1:0]  m1_done;
   logic        m0_fail;
   logic        m1_fail;
   logic        reset_fail;
   logic        ext_fail;
   wb_req_t     m0_req;
   wb_req_t     m1_req;
   wb_req_t     ext_req;
   wb_rsp_t     m0_rsp;
   wb_rsp_t     m1_rsp;
   wb_rsp_t     ext_rsp;
   int unsigned cycle_cnt = 0;
   int          ext_seed;
   logic        ext_busy;      // Ext slave counting down
   int unsigned ext_wait;

   initial clk = 1'b0;
   always #10 clk = ~clk;

   tile_bus_top #(
      .NUM_MASTERS (2),
      .DM_WORDS    (DM_WORDS_DEFAULT)
   ) u_dut (
      .clk       (clk),
      .rst_n_i   (rst_n),
      .m0_req_i  (m0_req),
      .m0_rsp_o  (m0_rsp),
      .m1_req_i  (m1_req),
      .m1_rsp_o  (m1_rsp),
      .ext_req_o (ext_req),
      .ext_rsp_i (ext_rsp)
   );

   tb_wb_master #(.MASTER_ID(0), .DIRECTED(1'b1), .N_RANDOM(N_RANDOM)) u_m0 (
      .clk (clk), .rst_n_i (rst_n), .phase_i (phase), .rsp_i (m0_rsp),
      .req_o (m0_req), .done_o (m0_done), .fail_o (m0_fail)
   );

   tb_wb_master #(.MASTER_ID(1), .DIRECTED(1'b0), .N_RANDOM(N_RANDOM)) u_m1 (
      .clk (clk), .rst_n_i (rst_n), .phase_i (phase), .rsp_i (m1_rsp),
      .req_o (m1_req), .done_o (m1_done), .fail_o (m1_fail)
   );

   task automatic abort_with_failure();
      $display("Test failed");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_low(input string name, input logic got);
      assert (got === 1'b0) else begin
         $display("error at %0t: %s expected 0 got %b", $time, name, got);
         reset_fail = 1'b1;
      end
   endtask

   // Payload of a master that is in a cycle
   function automatic bit issued_by(input wb_req_t m, input wb_req_t e);
      return m.cyc && m.stb && (m.we == e.we) && (m.sel == e.sel) &&
             (m.adr == e.adr) && (m.dat == e.dat);
   endfunction

   // Ext slave, ack after 1 to 4 cycles, data from the address
   initial begin
      ext_rsp  = '0;
      ext_busy = 1'b0;
      ext_wait = 0;
      ext_seed = 32'hd674821b;
      forever begin
         @(posedge clk);
         #(2*DRIVE_DLY);                            // After the masters have driven
         if (!rst_n) begin
            ext_rsp  = '0;
            ext_busy = 1'b0;
         end else if (ext_rsp.ack) begin
            ext_rsp = '0;                           // Single cycle ack
         end else if (ext_req.cyc && ext_req.stb) begin
            if (!ext_busy) begin
               ext_busy = 1'b1;
               ext_wait = 1 + ($unsigned($random(ext_seed)) % 4);
            end else begin
               ext_wait--;
               if (ext_wait == 0) begin
                  ext_busy    = 1'b0;
                  ext_rsp.ack = 1'b1;
                  ext_rsp.dat = ext_req.adr ^ 32'h5a5a5a5a;
               end
            end
         end
      end
   end

   // Ext port only carries ext window requests, unchanged
   always @(negedge clk) begin
      if (rst_n && ext_req.cyc && ext_req.stb) begin
         assert (ext_req.adr[31:28] === 4'he) else begin
            $display("error at %0t: ext_req_o.adr[31:28] expected e got %h",
                     $time, ext_req.adr[31:28]);
            ext_fail = 1'b1;
         end
         assert (issued_by(m0_req, ext_req) || issued_by(m1_req, ext_req)) else begin
            $display("ext_req_o at %0t carries a request that no master issued", $time);
            ext_fail = 1'b1;
         end
      end
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   initial begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("timeout after %0d cycles, the masters did not finish", cycle_cnt);
      abort_with_failure();
   end

   initial begin
      ext_fail = 1'b0;
      wait (m0_fail || m1_fail || reset_fail || ext_fail);
      $display("a bus check failed at %0t", $time);
      abort_with_failure();
   end

   initial begin
      rst_n      = 1'b0;
      phase      = 2'd0;
      reset_fail = 1'b0;
      repeat (3) @(posedge clk);
      #DRIVE_DLY;
      rst_n = 1'b1;
      @(negedge clk);
      check_low("m0_rsp_o.ack", m0_rsp.ack);      // Quiet bus after reset
      check_low("m0_rsp_o.err", m0_rsp.err);
      check_low("m1_rsp_o.ack", m1_rsp.ack);
      check_low("m1_rsp_o.err", m1_rsp.err);
      check_low("ext_req_o.cyc", ext_req.cyc);
      check_low("ext_req_o.stb", ext_req.stb);
      for (int p = 1; p <= 3; p++) begin           // Fill, directed, random
         @(posedge clk);
         #DRIVE_DLY;
         phase = 2'(p);
         wait (m0_done == 2'(p) && m1_done == 2'(p));
      end
      repeat (2) @(posedge clk);
      if (m0_fail || m1_fail || reset_fail || ext_fail) begin
         $display("a check failed before the end of the run");
         abort_with_failure();
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

// File: compile.f
rtl/tile_pkg.sv
rtl/bus_arbiter.sv
rtl/addr_decoder.sv
rtl/dm_sram.sv
rtl/tile_bus_top.sv
tb/tb_wb_master.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the tile bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f compile.f -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
